// File: sys_bus_pkg.sv
// System bus package
// Widths and vector types of the peripheral register bus, the address map
// of the device regions and the byte enable expansion shared by devices
package sys_bus_pkg;

  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusBeWidth   = BusDataWidth / 8;
  localparam int unsigned RegAddrWidth = 16; // Offset inside one 64 KiB region

  typedef logic [BusAddrWidth-1:0] bus_addr_t;
  typedef logic [BusDataWidth-1:0] bus_data_t;
  typedef logic [BusBeWidth-1:0]   bus_be_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  localparam bus_addr_t GpioBase   = 32'h8000_0000;
  localparam bus_addr_t TimerBase  = 32'h8004_0000;
  localparam bus_addr_t IntrBase   = 32'h8008_0000;
  localparam bus_addr_t RevTagBase = 32'h8010_0000;
  localparam bus_addr_t RegionMask = 32'hFFFF_0000; // Upper 16 bits pick the region

  // Expand byte enables to a bit mask over the data word
  function automatic bus_data_t be_mask(bus_be_t be);
    bus_data_t mask;
    mask = '0;
    for (int i = 0; i < BusBeWidth; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

// File: sys_periph_pkg.sv
// Peripheral package
// Device indices behind the decoder, interrupt source IDs and the register
// offsets of the GPIO, timer and interrupt blocks
package sys_periph_pkg;

  localparam int NrDevices = 4;

  localparam int DevGpio   = 0;
  localparam int DevTimer  = 1;
  localparam int DevIntr   = 2;
  localparam int DevRevTag = 3;

  typedef logic [7:0] irq_vec_t; // Indexed by interrupt ID

  localparam int IrqTimer = 1;
  localparam int IrqEth   = 2; // ID 0 stays tied to zero

  // Register offsets inside each region
  localparam logic [15:0] GpoReg         = 16'h0;
  localparam logic [15:0] GpiReg         = 16'h4;
  localparam logic [15:0] MtimeReg       = 16'h0;
  localparam logic [15:0] MtimecmpReg    = 16'h4;
  localparam logic [15:0] TimerCtrlReg   = 16'h8;
  localparam logic [15:0] IntrEnableReg  = 16'h0;
  localparam logic [15:0] IntrPendingReg = 16'h4;

endpackage

// File: dev_bus_if.sv
// Device register bus
// One request from the decoder to a device and the response coming back,
// which arrives exactly one cycle after the request
`timescale 1ns/100ps

interface dev_bus_if import sys_bus_pkg::*; ();

  logic      req;
  logic      we;
  reg_addr_t addr;   // Offset within the device region
  bus_be_t   be;
  bus_data_t wdata;
  logic      rvalid;
  bus_data_t rdata;  // Zero for writes

  modport decoder (
    output req, we, addr, be, wdata,
    input  rvalid, rdata
  );

  modport device (
    input  req, we, addr, be, wdata,
    output rvalid, rdata
  );

endinterface

// File: bus_decoder.sv
// Bus decoder
// Matches the top-level request against the address map and strobes one
// device with its region offset. Unmapped or out-of-range accesses get an
// error flag instead. Device responses and the error merge into one reply
`timescale 1ns/100ps

module bus_decoder import sys_bus_pkg::*, sys_periph_pkg::*; #(
  parameter int unsigned RevTagDepth = 4096
) (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,

  input  logic       req_i,
  input  logic       we_i,
  input  bus_addr_t  addr_i,
  input  bus_be_t    be_i,
  input  bus_data_t  wdata_i,
  output logic       rvalid_o,
  output bus_data_t  rdata_o,
  output logic       err_o,

  dev_bus_if.decoder gpio_bus,
  dev_bus_if.decoder timer_bus,
  dev_bus_if.decoder intr_bus,
  dev_bus_if.decoder tag_bus
);

  bus_addr_t              region;
  reg_addr_t              offset;
  logic                   tag_in_range;
  logic [NrDevices-1:0]   sel;
  logic [NrDevices-1:0]   dev_rvalid;
  bus_data_t              dev_rdata [NrDevices];
  logic                   err_q;

  assign region       = addr_i & RegionMask;
  assign offset       = addr_i[RegAddrWidth-1:0];
  assign tag_in_range = (32'(offset[RegAddrWidth-1:2]) < RevTagDepth); // Word index

  assign sel[DevGpio]   = (region == GpioBase);
  assign sel[DevTimer]  = (region == TimerBase);
  assign sel[DevIntr]   = (region == IntrBase);
  assign sel[DevRevTag] = (region == RevTagBase) & tag_in_range;

  ////////////////////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////////////////////

  assign gpio_bus.req   = req_i & sel[DevGpio];
  assign gpio_bus.we    = we_i;
  assign gpio_bus.addr  = offset;
  assign gpio_bus.be    = be_i;
  assign gpio_bus.wdata = wdata_i;

  assign timer_bus.req   = req_i & sel[DevTimer];
  assign timer_bus.we    = we_i;
  assign timer_bus.addr  = offset;
  assign timer_bus.be    = be_i;
  assign timer_bus.wdata = wdata_i;

  assign intr_bus.req   = req_i & sel[DevIntr];
  assign intr_bus.we    = we_i;
  assign intr_bus.addr  = offset;
  assign intr_bus.be    = be_i;
  assign intr_bus.wdata = wdata_i;

  assign tag_bus.req   = req_i & sel[DevRevTag];
  assign tag_bus.we    = we_i;
  assign tag_bus.addr  = offset;
  assign tag_bus.be    = be_i;
  assign tag_bus.wdata = wdata_i;

  // No device strobed, so answer with an error next cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i & ~(|sel);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////////////////////

  assign dev_rvalid[DevGpio]   = gpio_bus.rvalid;
  assign dev_rvalid[DevTimer]  = timer_bus.rvalid;
  assign dev_rvalid[DevIntr]   = intr_bus.rvalid;
  assign dev_rvalid[DevRevTag] = tag_bus.rvalid;

  assign dev_rdata[DevGpio]   = gpio_bus.rdata;
  assign dev_rdata[DevTimer]  = timer_bus.rdata;
  assign dev_rdata[DevIntr]   = intr_bus.rdata;
  assign dev_rdata[DevRevTag] = tag_bus.rdata;

  // At most one device answers per cycle
  always_comb begin
    rdata_o  = '0;
    rvalid_o = err_q;
    for (int i = 0; i < NrDevices; i++) begin
      if (dev_rvalid[i]) begin
        rdata_o = rdata_o | dev_rdata[i];
      end
      rvalid_o = rvalid_o | dev_rvalid[i];
    end
  end

  assign err_o = err_q;

endmodule

// File: gpio_regs.sv
// GPIO registers
// Two-flop synchroniser on the general-purpose inputs and a byte-writable
// output register driving the general-purpose outputs
`timescale 1ns/100ps

module gpio_regs import sys_bus_pkg::*, sys_periph_pkg::*; #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  dev_bus_if.device           bus,
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);

  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic [GpoWidth-1:0] gpo_q;
  bus_data_t           wmask;
  bus_data_t           gpo_merged;

  assign wmask      = be_mask(bus.be);
  assign gpo_merged = (bus_data_t'(gpo_q) & ~wmask) | (bus.wdata & wmask);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      gpo_q      <= '0;
      bus.rvalid <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;       // Inputs are asynchronous
      gpi_sync_q <= gpi_meta_q;
      bus.rvalid <= bus.req;
      if (bus.req && bus.we && (bus.addr == GpoReg)) begin
        gpo_q <= GpoWidth'(gpo_merged);
      end
    end
  end

  // Read data is zero on writes and on unused offsets
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      bus.rdata <= '0;
      if (!bus.we) begin
        case (bus.addr)
          GpoReg:  bus.rdata <= bus_data_t'(gpo_q);
          GpiReg:  bus.rdata <= bus_data_t'(gpi_sync_q);
          default: bus.rdata <= '0;
        endcase
      end
    end
  end

  assign gp_o = gpo_q;

endmodule

// File: mtimer.sv
// Machine timer
// Free-running 32-bit mtime counter with a compare register. The timer
// interrupt is a registered level, high while the timer is enabled and
// mtime has reached mtimecmp
`timescale 1ns/100ps

module mtimer import sys_bus_pkg::*, sys_periph_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,
  dev_bus_if.device bus,
  output logic      timer_irq_o
);

  bus_data_t mtime_q;
  bus_data_t mtimecmp_q;
  logic      enable_q;
  logic      irq_q;
  bus_data_t wmask;
  logic      wr_mtime;
  logic      wr_mtimecmp;
  logic      wr_ctrl;

  assign wmask       = be_mask(bus.be);
  assign wr_mtime    = bus.req & bus.we & (bus.addr == MtimeReg);
  assign wr_mtimecmp = bus.req & bus.we & (bus.addr == MtimecmpReg);
  assign wr_ctrl     = bus.req & bus.we & (bus.addr == TimerCtrlReg);

  ////////////////////////////////////////////////////////////////////////////
  // Counter and registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      enable_q   <= 1'b0;
    end else begin
      if (wr_mtime) begin
        mtime_q <= (mtime_q & ~wmask) | (bus.wdata & wmask); // Software load wins
      end else if (enable_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= (mtimecmp_q & ~wmask) | (bus.wdata & wmask);
      end
      if (wr_ctrl && bus.be[0]) begin
        enable_q <= bus.wdata[0];
      end
    end
  end

  // Compare result lags the registers by one cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_q      <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      irq_q      <= enable_q & (mtime_q >= mtimecmp_q);
      bus.rvalid <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      bus.rdata <= '0;
      if (!bus.we) begin
        case (bus.addr)
          MtimeReg:     bus.rdata <= mtime_q;
          MtimecmpReg:  bus.rdata <= mtimecmp_q;
          TimerCtrlReg: bus.rdata <= {31'b0, enable_q};
          default:      bus.rdata <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = irq_q;

endmodule

// File: rev_tag_ram.sv
// Revocation tag memory
// Single-port word array with byte-enabled writes and a registered read.
// Every request is answered one cycle later
`timescale 1ns/100ps

module rev_tag_ram import sys_bus_pkg::*; #(
  parameter int unsigned RevTagDepth = 4096
) (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,
  dev_bus_if.device bus
);

  localparam int unsigned TagAddrWidth = $clog2(RevTagDepth);

  bus_data_t               mem [RevTagDepth];
  logic [TagAddrWidth-1:0] word_idx;

  assign word_idx = bus.addr[TagAddrWidth+1:2]; // Byte offset to word index

  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int i = 0; i < BusBeWidth; i++) begin
          if (bus.be[i]) begin
            mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
        bus.rdata <= '0;
      end else begin
        bus.rdata <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
    end
  end

endmodule

// File: irq_collector.sv
// Interrupt collector
// Gathers the timer and Ethernet interrupts at fixed IDs, masks them with
// a software enable register and drives one registered external interrupt
`timescale 1ns/100ps

module irq_collector import sys_bus_pkg::*, sys_periph_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,
  dev_bus_if.device bus,
  input  logic      timer_irq_i,
  input  logic      eth_irq_ni,
  output logic      irq_o
);

  logic     eth_irq_q;
  irq_vec_t irq_vec;
  irq_vec_t enable_q;
  logic     irq_q;

  always_comb begin
    irq_vec           = '0; // ID 0 and unused IDs read zero
    irq_vec[IrqTimer] = timer_irq_i;
    irq_vec[IrqEth]   = eth_irq_q;
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      eth_irq_q  <= 1'b0;
      enable_q   <= '0;
      irq_q      <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      eth_irq_q  <= ~eth_irq_ni;          // Pin is active low
      irq_q      <= |(irq_vec & enable_q);
      bus.rvalid <= bus.req;
      if (bus.req && bus.we && (bus.addr == IntrEnableReg) && bus.be[0]) begin
        enable_q <= bus.wdata[7:0];
      end
    end
  end

  // Pending shows the raw sources, not the masked ones
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      bus.rdata <= '0;
      if (!bus.we) begin
        case (bus.addr)
          IntrEnableReg:  bus.rdata <= bus_data_t'(enable_q);
          IntrPendingReg: bus.rdata <= bus_data_t'(irq_vec);
          default:        bus.rdata <= '0;
        endcase
      end
    end
  end

  assign irq_o = irq_q;

endmodule

// File: periph_top.sv
// Peripheral subsystem top level
// A register bus request enters the decoder, which strobes the GPIO, the
// machine timer, the interrupt block or the revocation tag memory. The
// interrupt block turns the timer and Ethernet sources into irq_o
`timescale 1ns/100ps

module periph_top import sys_bus_pkg::*; #(
  parameter int unsigned GpiWidth    = 13,
  parameter int unsigned GpoWidth    = 24,
  parameter int unsigned RevTagDepth = 4096 // 16 KiB of tags
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  // Register bus
  input  logic                req_i,
  input  logic                we_i,
  input  bus_addr_t           addr_i,
  input  bus_be_t             be_i,
  input  bus_data_t           wdata_i,
  output logic                rvalid_o,
  output bus_data_t           rdata_o,
  output logic                err_o,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,

  input  logic                eth_irq_ni, // Ethernet MAC interrupt
  output logic                irq_o
);

  logic timer_irq;

  dev_bus_if gpio_bus ();
  dev_bus_if timer_bus ();
  dev_bus_if intr_bus ();
  dev_bus_if tag_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Decoder and devices
  ////////////////////////////////////////////////////////////////////////////

  bus_decoder #(
    .RevTagDepth ( RevTagDepth )
  ) u_bus_decoder (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .gpio_bus  (gpio_bus),
    .timer_bus (timer_bus),
    .intr_bus  (intr_bus),
    .tag_bus   (tag_bus)
  );

  gpio_regs #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth )
  ) u_gpio_regs (
    .clk_sys_i,
    .rst_sys_ni,
    .bus  (gpio_bus),
    .gp_i,
    .gp_o
  );

  mtimer u_mtimer (
    .clk_sys_i,
    .rst_sys_ni,
    .bus         (timer_bus),
    .timer_irq_o (timer_irq)
  );

  rev_tag_ram #(
    .RevTagDepth ( RevTagDepth )
  ) u_rev_tag_ram (
    .clk_sys_i,
    .rst_sys_ni,
    .bus (tag_bus)
  );

  irq_collector u_irq_collector (
    .clk_sys_i,
    .rst_sys_ni,
    .bus         (intr_bus),
    .timer_irq_i (timer_irq),
    .eth_irq_ni,
    .irq_o
  );

endmodule

// File: tb_periph_top.sv
// Testbench for the peripheral subsystem
// Directed tests drive the register bus through GPIO, timer, interrupt,
// tag memory and decode error cases and check each reply against a model
`timescale 1ns/100ps

module tb_periph_top import sys_bus_pkg::*, sys_periph_pkg::*; ();

  localparam int unsigned GpiWidth    = 13;
  localparam int unsigned GpoWidth    = 24;
  localparam int unsigned RevTagDepth = 4096;
  localparam int unsigned TagWords    = 64;
  localparam int unsigned MaxCycles   = 3000; // Tests need about 1200 cycles

  logic                clk_sys_i;
  logic                rst_sys_ni;
  logic                req_i;
  logic                we_i;
  bus_addr_t           addr_i;
  bus_be_t             be_i;
  bus_data_t           wdata_i;
  logic                rvalid_o;
  bus_data_t           rdata_o;
  logic                err_o;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic                eth_irq_ni;
  logic                irq_o;

  int unsigned cycle_count;
  int unsigned req_cycle;  // Cycle of the last request
  int          value_errors;
  int          protocol_errors;

  periph_top dut0 (.*);

  initial begin
    clk_sys_i = 1'b0;
    forever #20 clk_sys_i = ~clk_sys_i;
  end

  always @(posedge clk_sys_i) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= MaxCycles);
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_data(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_gpo(input logic [GpoWidth-1:0] got, input logic [GpoWidth-1:0] exp);
    if (got !== exp) begin
      $display("mismatch gp_o: got %h, expected %h", got, exp);
      value_errors++;
    end
  endtask

  // Reference byte merge for writes with byte enables
  function automatic bus_data_t merge_bytes(bus_data_t old_val, bus_data_t new_val, bus_be_t be);
    bus_data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic bus_access(input logic we, input bus_addr_t addr, input bus_be_t be,
                            input bus_data_t wdata, output bus_data_t rdata, output logic err);
    int late;
    @(negedge clk_sys_i);
    if (rvalid_o) begin
      $display("rvalid_o high with no request in flight");
      protocol_errors++;
    end
    req_i     = 1'b1;
    we_i      = we;
    addr_i    = addr;
    be_i      = be;
    wdata_i   = wdata;
    req_cycle = cycle_count;
    @(negedge clk_sys_i);
    req_i = 1'b0;
    late  = 0;
    while (!rvalid_o && late < 4) begin
      @(negedge clk_sys_i);
      late++;
    end
    if (!rvalid_o) begin
      $display("no response to the request at address %h", addr);
      protocol_errors++;
    end else if (late != 0) begin
      $display("response to address %h came %0d cycles late", addr, late);
      protocol_errors++;
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata,
                           output bus_data_t rdata, output logic err);
    bus_access(1'b1, addr, be, wdata, rdata, err);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t rdata, output logic err);
    bus_access(1'b0, addr, 4'hF, '0, rdata, err);
  endtask

  task automatic write_ok(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata);
    bus_data_t rdata;
    logic      err;
    bus_write(addr, be, wdata, rdata, err);
    compare_bit("err_o", err, 1'b0);
    compare_data("rdata_o on write", rdata, '0);
  endtask

  task automatic read_expect(input bus_addr_t addr, input bus_data_t exp, input string name);
    bus_data_t rdata;
    logic      err;
    bus_read(addr, rdata, err);
    compare_bit("err_o", err, 1'b0);
    compare_data(name, rdata, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic gpio_test();
    logic [GpoWidth-1:0] gpo_model;
    logic [GpiWidth-1:0] gpi_val;
    bus_data_t           data;
    bus_be_t             be;
    gpo_model = '0;
    for (int i = 0; i < 16; i++) begin
      data = $urandom();
      be   = bus_be_t'($urandom());
      write_ok(GpioBase + GpoReg, be, data);
      gpo_model = GpoWidth'(merge_bytes(bus_data_t'(gpo_model), data, be)); // Top byte unused
      compare_gpo(gp_o, gpo_model);
      read_expect(GpioBase + GpoReg, bus_data_t'(gpo_model), "GpoReg");
    end
    for (int i = 0; i < 4; i++) begin
      gpi_val = GpiWidth'($urandom());
      gp_i    = gpi_val;
      repeat (3) @(negedge clk_sys_i); // Through the synchroniser
      read_expect(GpioBase + GpiReg, bus_data_t'(gpi_val), "GpiReg");
    end
  endtask

  task automatic timer_count_test();
    bus_data_t   t1;
    bus_data_t   t2;
    int unsigned c1;
    logic        err;
    write_ok(TimerBase + MtimeReg, 4'hF, '0);
    write_ok(TimerBase + TimerCtrlReg, 4'h1, 32'h1);
    for (int i = 0; i < 3; i++) begin
      bus_read(TimerBase + MtimeReg, t1, err);
      compare_bit("err_o", err, 1'b0);
      c1 = req_cycle;
      repeat ($urandom_range(25, 1)) @(negedge clk_sys_i);
      bus_read(TimerBase + MtimeReg, t2, err);
      compare_bit("err_o", err, 1'b0);
      compare_data("mtime delta", t2 - t1, bus_data_t'(req_cycle - c1));
    end
  endtask

  task automatic timer_irq_test();
    bus_data_t now;
    logic      err;
    int        waited;
    bus_read(TimerBase + MtimeReg, now, err);
    compare_bit("err_o", err, 1'b0);
    write_ok(TimerBase + MtimecmpReg, 4'hF, now + 32'd50);
    write_ok(IntrBase + IntrEnableReg, 4'h1, 32'(1 << IrqTimer));
    @(negedge clk_sys_i);
    compare_bit("irq_o", irq_o, 1'b0);
    waited = 0;
    while (!irq_o && waited < 60) begin
      @(negedge clk_sys_i);
      waited++;
    end
    compare_bit("irq_o", irq_o, 1'b1);
    write_ok(TimerBase + MtimecmpReg, 4'hF, 32'hFFFF_0000);
    repeat (2) @(negedge clk_sys_i); // Compare flop, then irq flop
    compare_bit("irq_o", irq_o, 1'b0);
    write_ok(IntrBase + IntrEnableReg, 4'h1, '0);
  endtask

  task automatic eth_test();
    write_ok(IntrBase + IntrEnableReg, 4'h1, 32'(1 << IrqEth));
    eth_irq_ni = 1'b0;
    read_expect(IntrBase + IntrPendingReg, 32'(1 << IrqEth), "IntrPendingReg");
    compare_bit("irq_o", irq_o, 1'b1);
    eth_irq_ni = 1'b1;
    repeat (2) @(negedge clk_sys_i);
    compare_bit("irq_o", irq_o, 1'b0);
    read_expect(IntrBase + IntrPendingReg, '0, "IntrPendingReg");
    // Masked source stays pending but never reaches irq_o
    write_ok(IntrBase + IntrEnableReg, 4'h1, '0);
    eth_irq_ni = 1'b0;
    repeat (3) @(negedge clk_sys_i);
    compare_bit("irq_o", irq_o, 1'b0);
    read_expect(IntrBase + IntrPendingReg, 32'(1 << IrqEth), "IntrPendingReg");
    eth_irq_ni = 1'b1;
  endtask

  task automatic tag_test();
    int unsigned offs [TagWords];
    bus_data_t   model [int unsigned];
    bus_data_t   data;
    bus_be_t     be;
    for (int i = 0; i < TagWords; i++) begin
      offs[i] = $urandom_range(RevTagDepth - 1, 0);
      data    = $urandom();
      write_ok(RevTagBase + bus_addr_t'(offs[i] * 4), 4'hF, data); // Contents start undefined
      model[offs[i]] = data;
      data = $urandom();
      be   = bus_be_t'($urandom());
      write_ok(RevTagBase + bus_addr_t'(offs[i] * 4), be, data);
      model[offs[i]] = merge_bytes(model[offs[i]], data, be);
    end
    // Each reply lands while the next back-to-back read is driven
    for (int i = 0; i <= TagWords; i++) begin
      @(negedge clk_sys_i);
      if (i > 0) begin
        if (!rvalid_o) begin
          $display("no response to back-to-back tag read %0d", i - 1);
          protocol_errors++;
        end else begin
          compare_data("tag rdata_o", rdata_o, model[offs[i-1]]);
          compare_bit("err_o", err_o, 1'b0);
        end
      end
      req_i  = (i < TagWords);
      we_i   = 1'b0;
      be_i   = 4'hF;
      addr_i = (i < TagWords) ? RevTagBase + bus_addr_t'(offs[i] * 4) : '0;
    end
  endtask

  task automatic error_test();
    bus_addr_t bad_addr [3];
    bus_data_t rdata;
    logic      err;
    bad_addr[0] = 32'h9000_0000;
    bad_addr[1] = 32'h8002_0000;  // Hole between GPIO and timer
    bad_addr[2] = RevTagBase + bus_addr_t'(RevTagDepth * 4);
    for (int i = 0; i < 3; i++) begin
      bus_read(bad_addr[i], rdata, err);
      compare_bit("err_o", err, 1'b1);
      compare_data("rdata_o on error", rdata, '0);
      bus_write(bad_addr[i], 4'hF, $urandom(), rdata, err);
      compare_bit("err_o", err, 1'b1);
      compare_data("rdata_o on error", rdata, '0);
    end
    write_ok(GpioBase + GpiReg, 4'hF, ~bus_data_t'(gp_i));
    read_expect(GpioBase + GpiReg, bus_data_t'(gp_i), "GpiReg");
  endtask

  initial begin
    void'($urandom(32'h2e2c));
    cycle_count     = 0;
    value_errors    = 0;
    protocol_errors = 0;
    rst_sys_ni      = 1'b0;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    be_i            = '0;
    wdata_i         = '0;
    gp_i            = '0;
    eth_irq_ni      = 1'b1;
    repeat (16) @(negedge clk_sys_i);
    compare_bit("rvalid_o", rvalid_o, 1'b0);
    compare_bit("err_o", err_o, 1'b0);
    compare_bit("irq_o", irq_o, 1'b0);
    compare_gpo(gp_o, '0);
    rst_sys_ni = 1'b1;
    gpio_test();
    timer_count_test();
    timer_irq_test();
    eth_test();
    tag_test();
    error_test();
    $display("%0d value mismatches, %0d protocol errors", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
sys_bus_pkg.sv
sys_periph_pkg.sv
dev_bus_if.sv
bus_decoder.sv
gpio_regs.sv
mtimer.sv
rev_tag_ram.sv
irq_collector.sv
periph_top.sv
tb_periph_top.sv
